// File: common/bpu_params.svh
// Branch predictor parameters shared by the packages and the RTL blocks
`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// --------------------------------------------------
// Address format
// --------------------------------------------------
// Width of a program counter
`define XLEN 32

// Instruction alignment bits, always zero in a fetch address
`define OFFSET 2

// --------------------------------------------------
// Table sizes
// --------------------------------------------------
// BTB index width, 16 rows
`define BTB_BITS 4

// Pattern table index width, 64 counters
`define BHT_BITS 6

// Global history length, same as the pattern table index
`define GHR_LEN 6

`endif

// File: common/bpu_fetch_pkg.sv
// Fetch side types, used at the ports of the branch prediction unit
`include "bpu_params.svh"

package bpu_fetch_pkg;

  // --------------------------------------------------
  // Address types
  // --------------------------------------------------
  // Full program counter
  typedef logic [`XLEN-1:0] addr_t;

  // Target with the alignment bits removed
  typedef logic [`XLEN-`OFFSET-1:0] target_t;

  // --------------------------------------------------
  // Execute stage to predictor
  // --------------------------------------------------
  typedef struct packed {
    addr_t pc;
    addr_t target;
    logic  taken;
  } resolution_t;

  // --------------------------------------------------
  // Predictor to fetch stage
  // --------------------------------------------------
  typedef struct packed {
    logic  hit;
    logic  taken;
    addr_t target;
  } prediction_t;

endpackage

// File: common/bpu_counter_pkg.sv
// Direction predictor types: saturating counter, history and table index
`include "bpu_params.svh"

package bpu_counter_pkg;

  // --------------------------------------------------
  // Two-bit saturating counter
  // --------------------------------------------------
  // Upper bit gives the predicted direction
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } sat_cnt_t;

  // --------------------------------------------------
  // History and index
  // --------------------------------------------------
  // Newest outcome sits in bit 0
  typedef logic [`GHR_LEN-1:0] history_t;

  // Pattern table row select
  typedef logic [`BHT_BITS-1:0] bht_idx_t;

endpackage

// File: btb/btb.sv
// Branch target buffer: direct-mapped table of taken-branch targets
`timescale 1ns/100ps
`include "bpu_params.svh"

module btb #(
  parameter int unsigned BTB_BITS = `BTB_BITS
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  bpu_fetch_pkg::addr_t        pc_i,
  input  logic                        valid_i,
  input  logic                        del_entry_i,
  input  bpu_fetch_pkg::resolution_t  res_i,
  output logic                        hit_o,
  output bpu_fetch_pkg::target_t      target_o
);

  import bpu_fetch_pkg::*;

  // --------------------------------------------------
  // Table geometry
  // --------------------------------------------------
  localparam int unsigned BTB_ROWS = 1 << BTB_BITS;
  // Tag keeps every PC bit above the index
  localparam int unsigned TAG_W    = `XLEN - BTB_BITS - `OFFSET;

  // One row of the buffer
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    target_t          target;
  } btb_row_t;

  btb_row_t btb_d [BTB_ROWS];
  btb_row_t btb_q [BTB_ROWS];

  // Read and write side address split
  logic [BTB_BITS-1:0] rd_idx;
  logic [BTB_BITS-1:0] wr_idx;
  logic [TAG_W-1:0]    rd_tag;
  logic [TAG_W-1:0]    wr_tag;

  // --------------------------------------------------
  // Update from resolutions
  // --------------------------------------------------
  // Index bits sit just above the alignment bits
  assign wr_idx = res_i.pc[BTB_BITS+`OFFSET-1:`OFFSET];
  assign wr_tag = res_i.pc[`XLEN-1:BTB_BITS+`OFFSET];

  always_comb begin
    // Hold every row unless a resolution arrives
    btb_d = btb_q;
    if (valid_i) begin
      if (del_entry_i) begin
        // Not-taken branch frees its row whatever the tag
        btb_d[wr_idx] = '0;
      end else begin
        // Taken branch claims the row
        btb_d[wr_idx].valid  = 1'b1;
        btb_d[wr_idx].tag    = wr_tag;
        btb_d[wr_idx].target = res_i.target[`XLEN-1:`OFFSET];
      end
    end
  end

  // Flush wins over a resolution in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < BTB_ROWS; i++) begin
        btb_q[i] <= '0;
      end
    end else if (flush_i) begin
      for (int i = 0; i < BTB_ROWS; i++) begin
        btb_q[i] <= '0;
      end
    end else begin
      btb_q <= btb_d;
    end
  end

  // --------------------------------------------------
  // Lookup
  // --------------------------------------------------
  assign rd_idx = pc_i[BTB_BITS+`OFFSET-1:`OFFSET];
  assign rd_tag = pc_i[`XLEN-1:BTB_BITS+`OFFSET];

  // Hit needs a live row with a matching tag
  assign hit_o    = btb_q[rd_idx].valid & (btb_q[rd_idx].tag == rd_tag);
  // Target is passed without the alignment bits
  assign target_o = btb_q[rd_idx].target;

endmodule

// File: gshare/gshare.sv
// Gshare direction predictor that hashes global history with the PC into two-bit counters
`timescale 1ns/100ps
`include "bpu_params.svh"

module gshare (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  bpu_fetch_pkg::addr_t        pc_i,
  input  logic                        res_valid_i,
  input  bpu_fetch_pkg::resolution_t  res_i,
  output logic                        taken_o
);

  import bpu_counter_pkg::*;

  // --------------------------------------------------
  // State
  // --------------------------------------------------
  localparam int unsigned BHT_ROWS = 1 << `BHT_BITS;

  // Pattern table of saturating counters
  sat_cnt_t pht_q [BHT_ROWS];

  // Global history of resolved outcomes
  history_t ghr_q;
  history_t ghr_d;

  // Table row selects
  bht_idx_t rd_idx;
  bht_idx_t upd_idx;

  // Counter after one step toward the outcome
  sat_cnt_t upd_cnt;

  // --------------------------------------------------
  // Counter step with saturation
  // --------------------------------------------------
  function automatic sat_cnt_t cnt_step(input sat_cnt_t cnt, input logic taken);
    sat_cnt_t nxt;
    case (cnt)
      STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
      WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
      WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
      STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
      default:   nxt = WEAK_NT;
    endcase
    return nxt;
  endfunction

  // --------------------------------------------------
  // Lookup
  // --------------------------------------------------
  // PC index bits xor current history, same hash as the update side
  assign rd_idx = bht_idx_t'(pc_i[`BHT_BITS+`OFFSET-1:`OFFSET]) ^ ghr_q;

  // Upper counter bit gives the direction
  assign taken_o = (pht_q[rd_idx] == WEAK_T) || (pht_q[rd_idx] == STRONG_T);

  // --------------------------------------------------
  // Update
  // --------------------------------------------------
  assign upd_idx = bht_idx_t'(res_i.pc[`BHT_BITS+`OFFSET-1:`OFFSET]) ^ ghr_q;
  assign upd_cnt = cnt_step(pht_q[upd_idx], res_i.taken);

  // Outcome enters at bit 0 and the oldest bit drops out
  assign ghr_d = {ghr_q[`GHR_LEN-2:0], res_i.taken};

  // History register
  // Flush clears it and drops any resolution of that cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ghr_q <= '0;
    end else if (flush_i) begin
      ghr_q <= '0;
    end else if (res_valid_i) begin
      ghr_q <= ghr_d;
    end
  end

  // Counter table
  // Learned state survives a flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < BHT_ROWS; i++) begin
        pht_q[i] <= WEAK_NT;
      end
    end else if (res_valid_i && !flush_i) begin
      // Counter picked with the history before the shift
      pht_q[upd_idx] <= upd_cnt;
    end
  end

endmodule

// File: source/branch_predictor.sv
// Branch prediction unit top level: BTB target plus gshare direction
`timescale 1ns/100ps
`include "bpu_params.svh"

module branch_predictor (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  bpu_fetch_pkg::addr_t        pc_i,
  input  logic                        res_valid_i,
  input  bpu_fetch_pkg::resolution_t  res_i,
  output bpu_fetch_pkg::prediction_t  prediction_o
);

  import bpu_fetch_pkg::*;

  // --------------------------------------------------
  // Internal signals
  // --------------------------------------------------
  // BTB side
  logic    btb_hit;
  target_t btb_target;
  logic    btb_del;

  // Direction side
  logic    dir_taken;

  // --------------------------------------------------
  // Resolution routing
  // --------------------------------------------------
  // Not-taken branches free their BTB row
  assign btb_del = ~res_i.taken;

  // Target buffer
  btb #(
    .BTB_BITS    (`BTB_BITS)
  ) u_btb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .pc_i        (pc_i),
    .valid_i     (res_valid_i),
    .del_entry_i (btb_del),
    .res_i       (res_i),
    .hit_o       (btb_hit),
    .target_o    (btb_target)
  );

  // Direction predictor, trained on every resolution
  gshare u_gshare (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .pc_i        (pc_i),
    .res_valid_i (res_valid_i),
    .res_i       (res_i),
    .taken_o     (dir_taken)
  );

  // --------------------------------------------------
  // Prediction
  // --------------------------------------------------
  always_comb begin
    prediction_o.hit    = btb_hit;
    // Only a known branch can be predicted taken
    prediction_o.taken  = btb_hit & dir_taken;
    // Alignment bits restored as zeros
    prediction_o.target = {btb_target, {`OFFSET{1'b0}}};
  end

endmodule

// File: verif/tb_branch_predictor.sv
// Testbench for the branch prediction unit, replays operations from a vector file
`timescale 1ns/100ps

module tb_branch_predictor;

  import bpu_fetch_pkg::*;

  // --------------------------------------------------
  // Vector storage
  // --------------------------------------------------
  // One operation with its stimulus and expected lookup result
  typedef struct packed {
    logic [7:0] op;
    addr_t      pc;
    addr_t      target;
    logic       taken;
    logic       exp_hit;
    logic       exp_taken;
    addr_t      exp_target;
  } vector_t;

  vector_t vec_q[$];
  string   name_q[$];

  // --------------------------------------------------
  // DUT signals
  // --------------------------------------------------
  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        flush_i;
  addr_t       pc_i;
  logic        res_valid_i;
  resolution_t res_i;
  prediction_t prediction_o;

  // Run limit bookkeeping
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit;

  branch_predictor UUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .pc_i         (pc_i),
    .res_valid_i  (res_valid_i),
    .res_i        (res_i),
    .prediction_o (prediction_o)
  );

  // 8 ns clock
  always #4 clk_i = ~clk_i;

  // --------------------------------------------------
  // Failure and compare tasks
  // --------------------------------------------------
  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_hit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("error: %s hit expected %0b actual %0b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_taken(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("error: %s taken expected %0b actual %0b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_target(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("error: %s target expected %08h actual %08h", name, exp, act);
      abort_run();
    end
  endtask

  // Cycle counter, ends a run that no longer makes progress
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("simulation ran past %0d cycles without finishing", cycle_limit);
      abort_run();
    end
  end

  // --------------------------------------------------
  // Vector file reader
  // --------------------------------------------------
  // Lines starting with # are comments, blank lines are skipped
  task automatic load_vectors();
    int      fd;
    int      rc;
    string   line;
    string   op_s;
    string   name_s;
    addr_t   pc_v;
    addr_t   tgt_v;
    logic    tk_v;
    logic    hit_v;
    logic    tkn_v;
    addr_t   etgt_v;
    vector_t vec;
    fd = $fopen("verif/bpu_vectors.txt", "r");
    if (fd == 0) begin
      $display("vector file verif/bpu_vectors.txt could not be opened");
      abort_run();
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line.len() > 0 && line[0] != "#") begin
        rc = $sscanf(line, "%s %s %h %h %h %h %h %h", op_s, name_s, pc_v, tgt_v,
                     tk_v, hit_v, tkn_v, etgt_v);
        if (rc == 8) begin
          vec.op         = op_s[0];
          vec.pc         = pc_v;
          vec.target     = tgt_v;
          vec.taken      = tk_v;
          vec.exp_hit    = hit_v;
          vec.exp_taken  = tkn_v;
          vec.exp_target = etgt_v;
          if (vec.op != "R" && vec.op != "L" && vec.op != "F") begin
            $display("vector %s has an unknown operation %s", name_s, op_s);
            abort_run();
          end
          vec_q.push_back(vec);
          name_q.push_back(name_s);
        end else if (rc > 0) begin
          $display("vector line is missing fields: %s", line);
          abort_run();
        end
      end
    end
    $fclose(fd);
    if (vec_q.size() == 0) begin
      $display("vector file holds no operations");
      abort_run();
    end
  endtask

  // --------------------------------------------------
  // Operation driver
  // --------------------------------------------------
  // Inputs change on the rising edge, lookups sampled at the falling edge
  task automatic apply_vector(input vector_t vec, input string name);
    @(posedge clk_i);
    pc_i         <= vec.pc;
    res_valid_i  <= (vec.op == "R");
    flush_i      <= (vec.op == "F");
    res_i.pc     <= vec.pc;
    res_i.target <= vec.target;
    res_i.taken  <= vec.taken;
    if (vec.op == "L") begin
      @(negedge clk_i);
      check_hit(name, vec.exp_hit, prediction_o.hit);
      check_taken(name, vec.exp_taken, prediction_o.taken);
      // Target only carries meaning on a hit
      if (vec.exp_hit) begin
        check_target(name, vec.exp_target, prediction_o.target);
      end
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    pc_i        = '0;
    res_valid_i = 1'b0;
    res_i       = '0;
    cycle_limit = 0;

    load_vectors();
    // Each operation takes one cycle, generous margin on top
    cycle_limit = 4 * vec_q.size() + 20;

    // Reset held for three cycles
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    foreach (vec_q[i]) begin
      apply_vector(vec_q[i], name_q[i]);
    end

    // Let the last operation retire
    @(posedge clk_i);
    res_valid_i <= 1'b0;
    flush_i     <= 1'b0;
    @(posedge clk_i);

    $display("Regression passed");
    $finish;
  end

endmodule

// File: list.f
+incdir+common
common/bpu_fetch_pkg.sv
common/bpu_counter_pkg.sv
btb/btb.sv
gshare/gshare.sv
source/branch_predictor.sv
verif/tb_branch_predictor.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the branch predictor regression with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

# Compile the testbench together with the RTL
verilator --binary --timing -j 0 \
  --top-module tb_branch_predictor \
  -f list.f \
  -o tb_branch_predictor

# The log decides the result, not the simulator exit code
./obj_dir/tb_branch_predictor > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Regression passed" "$LOG"; then
  exit 0
else
  exit 1
fi

// File: verif/bpu_vectors.txt
# op name pc target taken exp_hit exp_taken exp_target
# op is R resolve, L lookup, F flush; numbers in hex, exp fields used by L only
# After reset
L reset_lookup_a     00001010 00000000 0 0 0 00000000
L reset_lookup_b     80000ffc 00000000 0 0 0 00000000
# First taken resolution, then a second branch trains the counter read for A
R first_taken_a      00001010 00002000 1 0 0 00000000
L first_taken_hit    00001010 00000000 0 1 0 00002000
R second_taken_c     00001018 00003000 1 0 0 00000000
L second_taken_a     00001010 00000000 0 1 1 00002000
L second_taken_c     00001018 00000000 0 1 0 00003000
# Same index, different tag
L tag_miss_d         00005010 00000000 0 0 0 00000000
R tag_overwrite_d    00005010 00006000 1 0 0 00000000
L tag_new_d          00005010 00000000 0 1 0 00006000
L tag_old_a          00001010 00000000 0 0 0 00000000
# Not-taken resolution frees the row
R delete_c           00001018 00003000 0 0 0 00000000
L delete_c_miss      00001018 00000000 0 0 0 00000000
L delete_d_kept      00005010 00000000 0 1 0 00006000
# Fill helper rows, then drive the history to all ones
R sat_fill_s2        00000a24 00004000 1 0 0 00000000
R sat_fill_q         00000a2c 00004400 1 0 0 00000000
R sat_up_1           00000a20 00004800 1 0 0 00000000
R sat_up_2           00000a20 00004800 1 0 0 00000000
R sat_up_3           00000a20 00004800 1 0 0 00000000
R sat_up_4           00000a20 00004800 1 0 0 00000000
# Counter 37 climbs and saturates
L sat_weak_nt        00000a20 00000000 0 1 0 00004800
R sat_up_5           00000a20 00004800 1 0 0 00000000
L sat_weak_t         00000a20 00000000 0 1 1 00004800
R sat_up_6           00000a20 00004800 1 0 0 00000000
R sat_up_7           00000a20 00004800 1 0 0 00000000
R sat_up_8           00000a20 00004800 1 0 0 00000000
L sat_strong_t       00000a20 00000000 0 1 1 00004800
# One step down keeps taken, a second step flips it
R sat_down_1         00000a20 00004800 0 0 0 00000000
L sat_hyst_s2        00000a24 00000000 0 1 1 00004000
L sat_deleted_s      00000a20 00000000 0 0 0 00000000
R sat_down_2         00000a24 00004000 0 0 0 00000000
L sat_flip_q         00000a2c 00000000 0 1 0 00004400
# Flush clears rows and history, counters survive
F flush              00000000 00000000 0 0 0 00000000
L flush_miss_d       00005010 00000000 0 0 0 00000000
L flush_miss_q       00000a2c 00000000 0 0 0 00000000
R flush_rewrite_c    00001018 00003000 1 0 0 00000000
L flush_trained_c    00001018 00000000 0 1 1 00003000
